//--- Makefile
VERILATOR  := verilator
SIM_FLAGS  := --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
TB_TOP     := tb_csi2_tx_ctrl
RTL_TOP    := csi2_tx_ctrl_top
FLIST      := flist.f
OBJ_DIR    := obj_dir
PASS_MSG   := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -o V$(TB_TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+hdl
hdl/csi2_tx_pkg.sv
hdl/dphy_delay_timer.sv
hdl/raw10_lane_packer.sv
hdl/lp_payload_engine.sv
hdl/csi2_frame_sequencer.sv
hdl/csi2_tx_ctrl_top.sv
test/tb_clk_gen.sv
test/tb_csi2_tx_ctrl.sv

//--- hdl/csi2_frame_sequencer.sv
`timescale 1ns/1ps
`include "csi2_tx_consts.svh"

module csi2_frame_sequencer import csi2_tx_pkg::*; (
	input  logic                         ctrl_tx_byte_clk_i,
	input  logic                         ctrl_tx_reset_i,
	input  logic                         pll_lock_i,
	input  logic                         tinit_done_i,
	input  logic                         start_stream_i,
	input  logic                         c2d_ready_i,
	input  logic                         d_hs_rdy_i,
	input  logic                         ld_pyld_i,
	input  logic [`NUM_DELAY_TIMERS-1:0] dly_done_i,
	input  logic                         payload_done_i,
	output logic [`NUM_DELAY_TIMERS-1:0] dly_start_o,
	output logic                         hs_en_o,
	output logic                         sp_en_o,
	output logic                         lp_en_o,
	output csi2_pkt_hdr_t                pkt_hdr_o,
	output logic                         payload_start_o,
	output lp_type_e                     lp_type_o,
	output logic                         line_odd_o,
	output line_count_t                  line_num_o
);

	localparam line_count_t LAST_LINE = line_count_t'(`LINES_PER_FRAME - 1);
	localparam word_count_t FRAME_MAX = word_count_t'(`FRAME_COUNT_MAX);
	localparam word_count_t EMB_WC    = word_count_t'(`EMBEDDED_LINE_BYTES);
	localparam word_count_t PIX_WC    = word_count_t'(`PIXEL_LINE_BYTES);

	seq_state_e    state_q;
	word_count_t   frame_cnt_q;
	line_count_t   line_num_q;
	logic          line_odd_q;
	lp_type_e      lp_type_q;
	logic          emb_second_q;    // Second embedded line in flight
	logic          short_pkt_q;     // Current packet is FS or FE
	logic          frame_end_q;
	csi2_pkt_hdr_t hdr_q;

	// Timer starts are held for as long as the state waits on them
	always_comb begin
		dly_start_o               = '0;
		dly_start_o[DLY_TINIT]    = (state_q == S_SETTLE);
		dly_start_o[DLY_HS]       = (state_q == S_HS_PULSE);
		dly_start_o[DLY_SP]       = (state_q == S_PKT_DLY) && short_pkt_q;
		dly_start_o[DLY_LP]       = (state_q == S_PKT_DLY) && !short_pkt_q;
		dly_start_o[DLY_EXPOSURE] = (state_q == S_EXPOSE);
	end

	assign hs_en_o         = (state_q == S_HS_PULSE);
	assign sp_en_o         = (state_q == S_SP_STROBE);
	assign lp_en_o         = (state_q == S_LP_STROBE);
	assign payload_start_o = (state_q == S_PYLD_START);
	assign pkt_hdr_o       = hdr_q;
	assign lp_type_o       = lp_type_q;
	assign line_odd_o      = line_odd_q;
	assign line_num_o      = line_num_q;

	always_ff @(posedge ctrl_tx_byte_clk_i or negedge ctrl_tx_reset_i) begin
		if (!ctrl_tx_reset_i) begin
			state_q      <= S_WAIT_PLL;
			frame_cnt_q  <= word_count_t'(1);
			line_num_q   <= '0;
			line_odd_q   <= 1'b0;
			lp_type_q    <= LP_EMBEDDED;
			emb_second_q <= 1'b0;
			short_pkt_q  <= 1'b0;
			frame_end_q  <= 1'b0;
			hdr_q        <= '0;
		end else begin
			case (state_q)
				S_WAIT_PLL: begin
					if (pll_lock_i) state_q <= S_WAIT_TINIT;
				end
				S_WAIT_TINIT: begin
					if (tinit_done_i) state_q <= S_WAIT_START;
				end
				S_WAIT_START: begin
					if (start_stream_i) begin
						frame_cnt_q <= word_count_t'(1);  // New stream restarts numbering
						state_q     <= S_SETTLE;
					end
				end
				S_SETTLE: begin
					if (dly_done_i[DLY_TINIT]) state_q <= S_FIRST_C2D;
				end
				S_FIRST_C2D: begin
					if (c2d_ready_i) begin
						short_pkt_q <= 1'b1;
						frame_end_q <= 1'b0;
						state_q     <= S_HS_PULSE;
					end
				end
				// Only place where a stream stop is taken
				S_FRAME_GAP: begin
					if (!start_stream_i) begin
						state_q <= S_WAIT_TINIT;
					end else if (c2d_ready_i) begin
						frame_cnt_q <= (frame_cnt_q == FRAME_MAX) ?
							word_count_t'(1) : frame_cnt_q + 1'b1;
						short_pkt_q <= 1'b1;
						frame_end_q <= 1'b0;
						state_q     <= S_EXPOSE;
					end
				end
				S_EXPOSE: begin
					if (dly_done_i[DLY_EXPOSURE]) state_q <= S_HS_PULSE;
				end
				S_WAIT_C2D_LP: begin
					if (c2d_ready_i) begin
						short_pkt_q <= 1'b0;
						state_q     <= S_HS_PULSE;
					end
				end
				S_WAIT_C2D_FE: begin
					if (c2d_ready_i) begin
						short_pkt_q <= 1'b1;
						frame_end_q <= 1'b1;
						state_q     <= S_HS_PULSE;
					end
				end
				S_HS_PULSE: begin
					if (dly_done_i[DLY_HS]) state_q <= S_WAIT_HS_RDY;
				end
				S_WAIT_HS_RDY: begin
					if (d_hs_rdy_i) begin
						if (short_pkt_q) begin
							hdr_q.dt <= frame_end_q ? `DT_FRAME_END : `DT_FRAME_START;
							hdr_q.wc <= frame_cnt_q;
						end else if (lp_type_q == LP_EMBEDDED) begin
							hdr_q.dt <= `DT_EMBEDDED;
							hdr_q.wc <= EMB_WC;
						end else begin
							hdr_q.dt <= `DT_RAW10;
							hdr_q.wc <= PIX_WC;
						end
						// Frame start rewinds the line bookkeeping
						if (short_pkt_q && !frame_end_q) begin
							lp_type_q    <= LP_EMBEDDED;
							emb_second_q <= 1'b0;
							line_num_q   <= '0;
							line_odd_q   <= 1'b0;
						end
						state_q <= S_PKT_DLY;
					end
				end
				S_PKT_DLY: begin
					if (short_pkt_q && dly_done_i[DLY_SP]) begin
						state_q <= S_SP_STROBE;
					end else if (!short_pkt_q && dly_done_i[DLY_LP]) begin
						state_q <= S_LP_STROBE;
					end
				end
				S_SP_STROBE: begin
					state_q <= frame_end_q ? S_FRAME_GAP : S_WAIT_C2D_LP;
				end
				S_LP_STROBE: begin
					state_q <= S_WAIT_PYLD;
				end
				S_WAIT_PYLD: begin
					if (!ld_pyld_i) state_q <= S_PYLD_START;  // One spare cycle follows
				end
				S_PYLD_START: begin
					state_q <= S_PAYLOAD;
				end
				S_PAYLOAD: begin
					if (payload_done_i) begin
						if (lp_type_q == LP_EMBEDDED) begin
							if (emb_second_q) lp_type_q <= LP_PIXEL;
							emb_second_q <= 1'b1;
							state_q      <= S_WAIT_C2D_LP;
						end else if (line_num_q == LAST_LINE) begin
							state_q <= S_WAIT_C2D_FE;
						end else begin
							line_num_q <= line_num_q + 1'b1;
							line_odd_q <= !line_odd_q;   // R/Gr and Gb/B alternate
							state_q    <= S_WAIT_C2D_LP;
						end
					end
				end
				default: begin
					state_q <= S_WAIT_PLL;
				end
			endcase
		end
	end

	// The payload engine only finishes a line that the FSM is waiting on
	a_done_in_payload: assert property (
		@(posedge ctrl_tx_byte_clk_i) disable iff (!ctrl_tx_reset_i)
		payload_done_i |-> (state_q == S_PAYLOAD)
	);

endmodule

//--- hdl/csi2_tx_consts.svh
`ifndef CSI2_TX_CONSTS_SVH
`define CSI2_TX_CONSTS_SVH

// Protocol delays, all in byte clocks
`define TINIT_WAIT_CYCLES       4
`define HS_PULSE_CYCLES         6
`define SP_EN_DELAY_CYCLES      7
`define LP_EN_DELAY_CYCLES      7
`define EXPOSURE_CYCLES         20

// Long packet word counts
`define PIXEL_LINE_BYTES        20     // Whole RAW10 groups on both lanes
`define EMBEDDED_LINE_BYTES     10
`define LINES_PER_FRAME         4

// CSI-2 data types
`define DT_FRAME_START          6'h00
`define DT_FRAME_END            6'h01
`define DT_EMBEDDED             6'h12
`define DT_RAW10                6'h2B

// Embedded data line content
`define EMB_FORMAT_CODE         8'h0A
`define EMB_END_CODE            8'h07
`define EMB_PAD_BYTE            8'h55

`define FRAME_COUNT_MAX         65534
`define NUM_DELAY_TIMERS        5

`endif

//--- hdl/csi2_tx_ctrl_top.sv
`timescale 1ns/1ps
`include "csi2_tx_consts.svh"

module csi2_tx_ctrl_top import csi2_tx_pkg::*; (
	input  logic          ctrl_tx_byte_clk_i,
	input  logic          ctrl_tx_reset_i,
	input  logic          ctrl_tx_pll_lock_i,
	input  logic          ctrl_tx_tinit_done_i,
	input  logic          ctrl_tx_start_stream_i,
	input  logic          ctrl_tx_c2d_ready_i,
	input  logic          ctrl_tx_d_hs_rdy_i,
	input  logic          ctrl_tx_ld_pyld_i,
	input  bayer_quad_t   ctrl_tx_pixel_i,
	output logic          ctrl_tx_clk_hs_en_o,
	output logic          ctrl_tx_d_hs_en_o,
	output logic          ctrl_tx_sp_en_o,
	output logic          ctrl_tx_lp_en_o,
	output logic          ctrl_tx_byte_data_en_o,
	output csi2_pkt_hdr_t ctrl_tx_pkt_hdr_o,
	output lane_bytes_t   ctrl_tx_byte_data_o,
	output line_count_t   ctrl_tx_line_num_o
);

	logic [`NUM_DELAY_TIMERS-1:0] dly_start;
	logic [`NUM_DELAY_TIMERS-1:0] dly_done;
	logic                         hs_en;
	logic                         payload_start;
	logic                         payload_done;
	lp_type_e                     lp_type;
	logic                         line_odd;

	// Clock and data lanes enter HS together
	assign ctrl_tx_clk_hs_en_o = hs_en;
	assign ctrl_tx_d_hs_en_o   = hs_en;

	csi2_frame_sequencer u_seq (
		.ctrl_tx_byte_clk_i (ctrl_tx_byte_clk_i),
		.ctrl_tx_reset_i    (ctrl_tx_reset_i),
		.pll_lock_i         (ctrl_tx_pll_lock_i),
		.tinit_done_i       (ctrl_tx_tinit_done_i),
		.start_stream_i     (ctrl_tx_start_stream_i),
		.c2d_ready_i        (ctrl_tx_c2d_ready_i),
		.d_hs_rdy_i         (ctrl_tx_d_hs_rdy_i),
		.ld_pyld_i          (ctrl_tx_ld_pyld_i),
		.dly_done_i         (dly_done),
		.payload_done_i     (payload_done),
		.dly_start_o        (dly_start),
		.hs_en_o            (hs_en),
		.sp_en_o            (ctrl_tx_sp_en_o),
		.lp_en_o            (ctrl_tx_lp_en_o),
		.pkt_hdr_o          (ctrl_tx_pkt_hdr_o),
		.payload_start_o    (payload_start),
		.lp_type_o          (lp_type),
		.line_odd_o         (line_odd),
		.line_num_o         (ctrl_tx_line_num_o)
	);

	for (genvar i = 0; i < `NUM_DELAY_TIMERS; i++) begin : g_dly
		// HS enable spans delay + 2 cycles in the sequencer
		localparam int DLY_CYCLES =
			(i == int'(DLY_TINIT)) ? `TINIT_WAIT_CYCLES :
			(i == int'(DLY_HS))    ? `HS_PULSE_CYCLES - 2 :
			(i == int'(DLY_SP))    ? `SP_EN_DELAY_CYCLES :
			(i == int'(DLY_LP))    ? `LP_EN_DELAY_CYCLES :
			`EXPOSURE_CYCLES;

		dphy_delay_timer #(
			.DELAY_CYCLES (DLY_CYCLES)
		) u_timer (
			.ctrl_tx_byte_clk_i (ctrl_tx_byte_clk_i),
			.ctrl_tx_reset_i    (ctrl_tx_reset_i),
			.start_i            (dly_start[i]),
			.done_o             (dly_done[i])
		);
	end

	lp_payload_engine u_payload (
		.ctrl_tx_byte_clk_i (ctrl_tx_byte_clk_i),
		.ctrl_tx_reset_i    (ctrl_tx_reset_i),
		.payload_start_i    (payload_start),
		.lp_type_i          (lp_type),
		.line_odd_i         (line_odd),
		.pixel_i            (ctrl_tx_pixel_i),
		.byte_data_en_o     (ctrl_tx_byte_data_en_o),
		.byte_data_o        (ctrl_tx_byte_data_o),
		.payload_done_o     (payload_done)
	);

endmodule

//--- hdl/csi2_tx_pkg.sv
`include "csi2_tx_consts.svh"

package csi2_tx_pkg;

	typedef logic [9:0]  pixel_t;
	typedef logic [7:0]  byte_t;
	typedef logic [5:0]  data_type_t;
	typedef logic [15:0] word_count_t;
	typedef logic [11:0] line_count_t;

	// One Bayer 2x2 cell
	typedef struct packed {
		pixel_t r;
		pixel_t gr;
		pixel_t gb;
		pixel_t b;
	} bayer_quad_t;

	typedef struct packed {
		byte_t lane1;
		byte_t lane0;
	} lane_bytes_t;

	// Header fields handed to the transmitter core, VC fixed at 0
	typedef struct packed {
		data_type_t  dt;
		word_count_t wc;
	} csi2_pkt_hdr_t;

	typedef enum logic {
		LP_EMBEDDED,
		LP_PIXEL
	} lp_type_e;

	// Index into the delay timer bank
	typedef enum logic [$clog2(`NUM_DELAY_TIMERS)-1:0] {
		DLY_TINIT,
		DLY_HS,
		DLY_SP,
		DLY_LP,
		DLY_EXPOSURE
	} delay_sel_e;

	typedef enum logic [4:0] {
		S_WAIT_PLL,
		S_WAIT_TINIT,
		S_WAIT_START,
		S_SETTLE,
		S_FIRST_C2D,     // First frame, no exposure
		S_FRAME_GAP,     // Between frames
		S_EXPOSE,
		S_WAIT_C2D_LP,
		S_WAIT_C2D_FE,
		S_HS_PULSE,
		S_WAIT_HS_RDY,
		S_PKT_DLY,
		S_SP_STROBE,
		S_LP_STROBE,
		S_WAIT_PYLD,
		S_PYLD_START,
		S_PAYLOAD
	} seq_state_e;

	typedef enum logic [2:0] {
		GEAR_BYTE1,
		GEAR_BYTE2,
		GEAR_BYTE3,
		GEAR_BYTE4,
		GEAR_BYTE5
	} gear_state_e;

endpackage

//--- hdl/dphy_delay_timer.sv
`timescale 1ns/1ps

module dphy_delay_timer #(
	parameter int DELAY_CYCLES = 4
) (
	input  logic ctrl_tx_byte_clk_i,
	input  logic ctrl_tx_reset_i,
	input  logic start_i,
	output logic done_o
);

	localparam int CW = $clog2(DELAY_CYCLES + 2);

	logic [CW-1:0] cnt_q;

	always_ff @(posedge ctrl_tx_byte_clk_i or negedge ctrl_tx_reset_i) begin
		if (!ctrl_tx_reset_i) begin
			cnt_q  <= CW'(DELAY_CYCLES);
			done_o <= 1'b0;
		end else begin
			if (!start_i) begin
				cnt_q <= CW'(DELAY_CYCLES);     // Reload while idle
			end else if (cnt_q != '0) begin
				cnt_q <= cnt_q - 1'b1;
			end
			done_o <= start_i && (cnt_q == '0);
		end
	end

	// Done only rises once start has been held over the whole delay
	a_done_after_start: assert property (
		@(posedge ctrl_tx_byte_clk_i) disable iff (!ctrl_tx_reset_i)
		$rose(done_o) |-> $past(start_i) && $past(start_i, DELAY_CYCLES + 1)
	);

endmodule

//--- hdl/lp_payload_engine.sv
`timescale 1ns/1ps
`include "csi2_tx_consts.svh"

module lp_payload_engine import csi2_tx_pkg::*; (
	input  logic        ctrl_tx_byte_clk_i,
	input  logic        ctrl_tx_reset_i,
	input  logic        payload_start_i,
	input  lp_type_e    lp_type_i,
	input  logic        line_odd_i,
	input  bayer_quad_t pixel_i,
	output logic        byte_data_en_o,
	output lane_bytes_t byte_data_o,
	output logic        payload_done_o
);

	// Two bytes per cycle across the lanes
	localparam word_count_t EMB_LAST = word_count_t'(`EMBEDDED_LINE_BYTES / 2 - 1);
	localparam word_count_t PIX_LAST = word_count_t'(`PIXEL_LINE_BYTES / 2 - 1);

	lp_type_e    lp_type_q;
	logic        line_odd_q;
	logic        active_q;
	word_count_t cycle_q;
	word_count_t last_cycle;
	lane_bytes_t emb_bytes;
	lane_bytes_t pix_bytes;

	assign last_cycle = (lp_type_q == LP_EMBEDDED) ? EMB_LAST : PIX_LAST;

	always_ff @(posedge ctrl_tx_byte_clk_i or negedge ctrl_tx_reset_i) begin
		if (!ctrl_tx_reset_i) begin
			active_q   <= 1'b0;
			cycle_q    <= '0;
			lp_type_q  <= LP_EMBEDDED;
			line_odd_q <= 1'b0;
		end else if (payload_start_i) begin
			active_q   <= 1'b1;
			cycle_q    <= '0;
			lp_type_q  <= lp_type_i;      // Held for the whole line
			line_odd_q <= line_odd_i;
		end else if (active_q) begin
			if (cycle_q == last_cycle) begin
				active_q <= 1'b0;
			end
			cycle_q <= cycle_q + 1'b1;
		end
	end

	// Format code first, pad byte last, end codes between
	assign emb_bytes.lane0 = (cycle_q == '0) ? `EMB_FORMAT_CODE : `EMB_END_CODE;
	assign emb_bytes.lane1 = (cycle_q == EMB_LAST) ? `EMB_PAD_BYTE : `EMB_END_CODE;

	raw10_lane_packer u_packer (
		.ctrl_tx_byte_clk_i (ctrl_tx_byte_clk_i),
		.ctrl_tx_reset_i    (ctrl_tx_reset_i),
		.advance_i          (active_q),
		.line_odd_i         (line_odd_q),
		.pixel_i            (pixel_i),
		.lane_o             (pix_bytes)
	);

	assign byte_data_o    = (lp_type_q == LP_EMBEDDED) ? emb_bytes : pix_bytes;
	assign byte_data_en_o = active_q;
	assign payload_done_o = active_q && (cycle_q == last_cycle);

	// The sequencer must wait for the previous line to drain
	a_no_overlap: assert property (
		@(posedge ctrl_tx_byte_clk_i) disable iff (!ctrl_tx_reset_i)
		payload_start_i |-> !byte_data_en_o
	);

endmodule

//--- hdl/raw10_lane_packer.sv
`timescale 1ns/1ps

module raw10_lane_packer import csi2_tx_pkg::*; (
	input  logic        ctrl_tx_byte_clk_i,
	input  logic        ctrl_tx_reset_i,
	input  logic        advance_i,
	input  logic        line_odd_i,
	input  bayer_quad_t pixel_i,
	output lane_bytes_t lane_o
);

	gear_state_e gear_q;
	gear_state_e gear_d;
	pixel_t      pix_a;
	pixel_t      pix_b;
	byte_t       low_bits;

	// Even lines carry R/Gr, odd lines Gb/B
	assign pix_a = line_odd_i ? pixel_i.gb : pixel_i.r;
	assign pix_b = line_odd_i ? pixel_i.b : pixel_i.gr;

	// Group is a, b, a, b so pixel n low bits sit at [2n+1:2n]
	assign low_bits = {pix_b[1:0], pix_a[1:0], pix_b[1:0], pix_a[1:0]};

	// Gear names the stream byte that lands on lane0 this cycle
	always_comb begin
		gear_d       = GEAR_BYTE1;
		lane_o.lane0 = pix_a[9:2];
		lane_o.lane1 = pix_b[9:2];
		case (gear_q)
			GEAR_BYTE1: begin
				gear_d = GEAR_BYTE3;
			end
			GEAR_BYTE3: begin
				gear_d = GEAR_BYTE5;
			end
			GEAR_BYTE5: begin
				lane_o.lane0 = low_bits;
				lane_o.lane1 = pix_a[9:2];     // First byte of next group
				gear_d       = GEAR_BYTE2;
			end
			GEAR_BYTE2: begin
				lane_o.lane0 = pix_b[9:2];
				lane_o.lane1 = pix_a[9:2];
				gear_d       = GEAR_BYTE4;
			end
			GEAR_BYTE4: begin
				lane_o.lane0 = pix_b[9:2];
				lane_o.lane1 = low_bits;
				gear_d       = GEAR_BYTE1;
			end
			default: begin
				gear_d = GEAR_BYTE1;
			end
		endcase
	end

	always_ff @(posedge ctrl_tx_byte_clk_i or negedge ctrl_tx_reset_i) begin
		if (!ctrl_tx_reset_i) begin
			gear_q <= GEAR_BYTE1;
		end else begin
			gear_q <= advance_i ? gear_d : GEAR_BYTE1;
		end
	end

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 5
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	// Release lands on a falling edge, away from the DUT's rising edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

//--- test/tb_csi2_tx_ctrl.sv
`timescale 1ns/1ps
`include "csi2_tx_consts.svh"

module tb_csi2_tx_ctrl import csi2_tx_pkg::*; ();

	localparam int WAIT_LIMIT   = 200;    // Cycles allowed for any one handshake
	localparam int QUIET_CYCLES = 150;
	localparam int GATE_CYCLES  = 40;     // Longer than a whole Frame Start
	localparam int MAX_BEATS    = 32;
	localparam int NUM_ROWS     = 4;

	typedef struct packed {
		bayer_quad_t pix;
		word_count_t wc;             // Expected FS/FE word count
		logic        start_after;    // Start-stream level once the frame has ended
	} frame_row_t;

	logic          clk;
	logic          rst_n;
	logic          pll_lock;
	logic          tinit_done;
	logic          start_stream;
	logic          c2d_ready;
	logic          d_hs_rdy;
	logic          ld_pyld;
	bayer_quad_t   pixel;
	logic          clk_hs_en;
	logic          d_hs_en;
	logic          sp_en;
	logic          lp_en;
	logic          byte_en;
	csi2_pkt_hdr_t pkt_hdr;
	lane_bytes_t   lane_data;
	line_count_t   line_num;

	frame_row_t rows [NUM_ROWS];
	byte_t      got_lane0 [MAX_BEATS];
	byte_t      got_lane1 [MAX_BEATS];
	int         seed = 32'h51772d9a;
	int         errors;
	int         test_errors;
	int         tests_run;
	int         tests_failed;
	logic       aborted;

	tb_clk_gen u_clk_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	csi2_tx_ctrl_top u_csi2_tx_ctrl_top (
		.ctrl_tx_byte_clk_i     (clk),
		.ctrl_tx_reset_i        (rst_n),
		.ctrl_tx_pll_lock_i     (pll_lock),
		.ctrl_tx_tinit_done_i   (tinit_done),
		.ctrl_tx_start_stream_i (start_stream),
		.ctrl_tx_c2d_ready_i    (c2d_ready),
		.ctrl_tx_d_hs_rdy_i     (d_hs_rdy),
		.ctrl_tx_ld_pyld_i      (ld_pyld),
		.ctrl_tx_pixel_i        (pixel),
		.ctrl_tx_clk_hs_en_o    (clk_hs_en),
		.ctrl_tx_d_hs_en_o      (d_hs_en),
		.ctrl_tx_sp_en_o        (sp_en),
		.ctrl_tx_lp_en_o        (lp_en),
		.ctrl_tx_byte_data_en_o (byte_en),
		.ctrl_tx_pkt_hdr_o      (pkt_hdr),
		.ctrl_tx_byte_data_o    (lane_data),
		.ctrl_tx_line_num_o     (line_num)
	);

	function automatic int random_gap();
		return int'({$random(seed)} % 32'd8);    // 0 to 7 cycles
	endfunction

	function automatic byte_t embedded_byte(input int idx);
		if (idx == 0) return 8'h0A;
		if (idx == `EMBEDDED_LINE_BYTES - 1) return 8'h55;
		return 8'h07;
	endfunction

	// Stream byte idx of a RAW10 line, four high bytes then the packed low bits
	function automatic byte_t raw10_byte(input bayer_quad_t q, input logic odd, input int idx);
		pixel_t grp [4];
		byte_t  low;
		int     n;
		grp[0] = odd ? q.gb : q.r;
		grp[1] = odd ? q.b : q.gr;
		grp[2] = grp[0];
		grp[3] = grp[1];
		low    = '0;
		for (n = 0; n < 4; n++) begin
			low[2*n +: 2] = grp[n][1:0];
		end
		if ((idx % 5) < 4) return grp[idx % 5][9:2];
		return low;
	endfunction

	task automatic set_row(input int idx, input pixel_t r, input pixel_t gr, input pixel_t gb,
			input pixel_t b, input word_count_t wc, input logic start_after);
		rows[idx].pix.r       = r;
		rows[idx].pix.gr      = gr;
		rows[idx].pix.gb      = gb;
		rows[idx].pix.b       = b;
		rows[idx].wc          = wc;
		rows[idx].start_after = start_after;
	endtask

	task automatic report_error(input string msg);
		$display("FAIL t=%0t: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	task automatic give_up(input string what);
		$display("Gave up after %0d cycles waiting for %s", WAIT_LIMIT, what);
		errors++;
		test_errors++;
		aborted = 1'b1;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic wait_reset_release();
		int n;
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(negedge clk);
			if (rst_n) break;
		end
		if (n == WAIT_LIMIT) give_up("reset release");
	endtask

	task automatic check_idle(input int cycles, input string phase);
		int n;
		for (n = 0; n < cycles; n++) begin
			@(negedge clk);
			if (clk_hs_en || d_hs_en || sp_en || lp_en || byte_en)
				report_error($sformatf("output active during %s", phase));
			if (pkt_hdr !== '0)
				report_error($sformatf("header %h not zero during %s", pkt_hdr, phase));
		end
	endtask

	task automatic wait_for_strobe(input string what, output logic is_sp,
			output csi2_pkt_hdr_t hdr, output line_count_t ln);
		int n;
		is_sp = 1'b0;
		hdr   = '0;
		ln    = '0;
		if (aborted) return;
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(negedge clk);
			if (sp_en || lp_en) break;
		end
		if (n == WAIT_LIMIT) begin
			give_up(what);
			return;
		end
		is_sp = sp_en;
		hdr   = pkt_hdr;
		ln    = line_num;
	endtask

	task automatic collect_payload(input string what, output int beats);
		int n;
		beats = 0;
		if (aborted) return;
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(negedge clk);
			if (byte_en) break;
		end
		if (n == WAIT_LIMIT) begin
			give_up($sformatf("byte_en of %s", what));
			return;
		end
		while (byte_en && beats < MAX_BEATS) begin
			got_lane0[beats] = lane_data.lane0;
			got_lane1[beats] = lane_data.lane1;
			beats++;
			@(negedge clk);
		end
		if (beats == MAX_BEATS) give_up($sformatf("byte_en of %s to fall", what));
	endtask

	task automatic expect_short(input data_type_t dt, input word_count_t wc, input string what);
		logic          is_sp;
		csi2_pkt_hdr_t hdr;
		line_count_t   ln;
		wait_for_strobe(what, is_sp, hdr, ln);
		if (aborted) return;
		if (!is_sp) report_error($sformatf("%s came with lp_en instead of sp_en", what));
		if (hdr.dt !== dt) report_error($sformatf("%s DT %h, expected %h", what, hdr.dt, dt));
		if (hdr.wc !== wc) report_error($sformatf("%s WC %0d, expected %0d", what, hdr.wc, wc));
	endtask

	task automatic expect_long(input logic pixel_line, input int line_idx, input bayer_quad_t q,
			input string what);
		logic          is_sp;
		csi2_pkt_hdr_t hdr;
		line_count_t   ln;
		int            beats;
		int            b;
		logic          odd;
		data_type_t    want_dt;
		word_count_t   want_wc;
		byte_t         exp0;
		byte_t         exp1;
		want_dt = pixel_line ? 6'h2B : 6'h12;
		want_wc = pixel_line ? word_count_t'(`PIXEL_LINE_BYTES) :
			word_count_t'(`EMBEDDED_LINE_BYTES);
		odd     = (line_idx % 2) == 1;
		wait_for_strobe(what, is_sp, hdr, ln);
		if (aborted) return;
		if (is_sp) report_error($sformatf("%s came with sp_en instead of lp_en", what));
		if (hdr.dt !== want_dt)
			report_error($sformatf("%s DT %h, expected %h", what, hdr.dt, want_dt));
		if (hdr.wc !== want_wc)
			report_error($sformatf("%s WC %0d, expected %0d", what, hdr.wc, want_wc));
		if (pixel_line && ln !== line_count_t'(line_idx))
			report_error($sformatf("%s line number %0d", what, ln));
		collect_payload(what, beats);
		if (aborted) return;
		if (beats != int'(want_wc) / 2)
			report_error($sformatf("%s byte_en held %0d cycles, expected %0d", what, beats,
				want_wc / 2));
		for (b = 0; b < beats && b < int'(want_wc) / 2; b++) begin
			exp0 = pixel_line ? raw10_byte(q, odd, 2 * b) : embedded_byte(2 * b);
			exp1 = pixel_line ? raw10_byte(q, odd, 2 * b + 1) : embedded_byte(2 * b + 1);
			if (got_lane0[b] !== exp0 || got_lane1[b] !== exp1)
				report_error($sformatf("%s beat %0d lanes %h/%h, expected %h/%h", what, b,
					got_lane1[b], got_lane0[b], exp1, exp0));
		end
	endtask

	task automatic watch_quiet(input int cycles);
		int n;
		for (n = 0; n < cycles; n++) begin
			@(negedge clk);
			if (sp_en || lp_en) report_error("strobe seen after start-stream was dropped");
		end
	endtask

	// PHY core model, one packet at a time
	initial begin : phy_responder
		int   c2d_cnt;     // -1 means no rise pending
		int   rdy_cnt;
		int   ld_cnt;
		int   hs_len;
		logic hs_prev;
		logic byte_prev;
		c2d_ready = 1'b0;
		d_hs_rdy  = 1'b0;
		ld_pyld   = 1'b0;
		c2d_cnt   = random_gap();
		rdy_cnt   = -1;
		ld_cnt    = 0;
		hs_len    = 0;
		hs_prev   = 1'b0;
		byte_prev = 1'b0;
		forever begin
			@(negedge clk);
			if (rst_n) begin
				if (clk_hs_en !== d_hs_en)
					report_error("clock and data HS enables differ");
				// HS pulse width seen by the core
				if (clk_hs_en) begin
					hs_len++;
				end else if (hs_prev) begin
					if (hs_len != `HS_PULSE_CYCLES)
						report_error($sformatf("HS enable held %0d cycles, expected %0d",
							hs_len, `HS_PULSE_CYCLES));
					hs_len = 0;
				end
				if (clk_hs_en && !hs_prev) begin
					c2d_ready = 1'b0;    // Core busy with the new packet
					rdy_cnt   = random_gap();
				end
				if (rdy_cnt == 0) begin
					d_hs_rdy = 1'b1;
					rdy_cnt  = -1;
				end else if (rdy_cnt > 0) begin
					rdy_cnt--;
				end
				if (sp_en || lp_en) d_hs_rdy = 1'b0;
				if (sp_en) c2d_cnt = random_gap();
				if (lp_en) ld_cnt = 3;
				if (byte_prev && !byte_en) c2d_cnt = random_gap();
				if (ld_cnt > 0) begin
					ld_pyld = 1'b1;
					ld_cnt--;
				end else begin
					ld_pyld = 1'b0;
				end
				if (c2d_cnt == 0) begin
					c2d_ready = 1'b1;
					c2d_cnt   = -1;
				end else if (c2d_cnt > 0) begin
					c2d_cnt--;
				end
				hs_prev   = clk_hs_en;
				byte_prev = byte_en;
			end
		end
	end

	initial begin : main_flow
		int r;
		int ln;
		errors       = 0;
		test_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		aborted      = 1'b0;
		set_row(0, 10'h3FF, 10'h001, 10'h2AA, 10'h155, 16'd1, 1'b1);
		set_row(1, 10'h123, 10'h2DE, 10'h0F0, 10'h30F, 16'd2, 1'b1);
		set_row(2, 10'h201, 10'h1FE, 10'h3C3, 10'h03C, 16'd3, 1'b1);
		set_row(3, 10'h096, 10'h369, 10'h2B1, 10'h14E, 16'd4, 1'b0);    // Stream stops after it
		pll_lock     = 1'b0;
		tinit_done   = 1'b0;
		start_stream = 1'b0;
		pixel        = rows[0].pix;

		wait_reset_release();
		check_idle(10, "idle after reset");
		tinit_done   = 1'b1;
		start_stream = 1'b1;
		check_idle(GATE_CYCLES, "wait for PLL lock");
		tinit_done = 1'b0;     // Lock arrives ahead of tinit done
		pll_lock   = 1'b1;
		check_idle(GATE_CYCLES, "wait for tinit done");
		tinit_done = 1'b1;
		finish_test("power-up");

		for (r = 0; r < NUM_ROWS && !aborted; r++) begin
			pixel = rows[r].pix;     // Held for the whole frame
			expect_short(6'h00, rows[r].wc, "frame start");
			expect_long(1'b0, 0, rows[r].pix, "embedded line 0");
			expect_long(1'b0, 1, rows[r].pix, "embedded line 1");
			for (ln = 0; ln < `LINES_PER_FRAME; ln++) begin
				expect_long(1'b1, ln, rows[r].pix, $sformatf("pixel line %0d", ln));
			end
			expect_short(6'h01, rows[r].wc, "frame end");
			start_stream = rows[r].start_after;
			finish_test($sformatf("frame %0d", r + 1));
		end

		if (!aborted) begin
			watch_quiet(QUIET_CYCLES);
			finish_test("stream stop");
		end

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && !aborted) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
